//--- common/pmp_pkg.sv
// Register offsets, generator states, control and status bit positions and APB widths
`default_nettype none

package pmp_pkg;

    // Widths of the APB slave port
    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;

    // Byte offsets of the register map, one 32-bit word each
    typedef enum logic [APB_ADDR_WIDTH-1:0] {
        REG_CTRL     = 8'h00,
        REG_PERIOD   = 8'h04,
        REG_PHASE    = 8'h08,
        REG_DEADTIME = 8'h0C,
        REG_STATUS   = 8'h10
    } pmp_reg_addr_e;

    // Gate generator state, idle keeps every gate low
    typedef enum logic {
        GEN_IDLE = 1'b0,
        GEN_RUN  = 1'b1
    } pmp_gen_state_e;

    // Control word layout
    // Enable is a level, apply is a self-clearing command bit
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_APPLY_BIT  = 1;

    // Status word layout
    // The error bit is sticky until the next good result
    // The loaded bit clears when the status word is read
    localparam int STATUS_CFG_ERR_BIT = 0;
    localparam int STATUS_LOADED_BIT  = 1;

endpackage

`default_nettype wire

//--- verilog/pmp_apb_regs.sv
// APB register block for period, phase, dead time, control and status readback
`timescale 1ns/1ps
`default_nettype none

module pmp_apb_regs #(
    parameter int COUNTER_WIDTH = 16
) (
    input  wire                                  clock,
    input  wire                                  arst_n,
    input  wire  [pmp_pkg::APB_ADDR_WIDTH-1:0]   paddr,
    input  wire                                  psel,
    input  wire                                  penable,
    input  wire                                  pwrite,
    input  wire  [pmp_pkg::APB_DATA_WIDTH-1:0]   pwdata,
    output logic [pmp_pkg::APB_DATA_WIDTH-1:0]   prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    input  wire                                  cfg_err,
    input  wire                                  result_valid,
    input  wire                                  loaded,
    output logic [COUNTER_WIDTH-1:0]             period,
    output logic [COUNTER_WIDTH-1:0]             phase,
    output logic [COUNTER_WIDTH-1:0]             dead_time,
    output logic                                 apply,
    output logic                                 enable
);

    logic                                access;
    logic                                wr_en;
    logic                                rd_en;
    logic                                addr_hit;
    logic                                status_rd;
    logic                                err_flag;
    logic                                loaded_flag;
    logic [pmp_pkg::APB_DATA_WIDTH-1:0]  rd_word;

    // Only the access phase counts, the setup phase is ignored
    assign access = psel && penable;
    // A write or read to an unmapped offset is dropped and flagged
    assign wr_en  = access && pwrite && addr_hit;
    assign rd_en  = access && !pwrite && addr_hit;

    // Zero wait states, so the slave is always ready
    assign pready  = 1'b1;
    assign pslverr = access && !addr_hit;
    // Read data is only presented during a valid read access
    assign prdata  = rd_en ? rd_word : '0;

    assign status_rd = rd_en && (paddr == pmp_pkg::REG_STATUS);

    // Address decode and readback mux
    always_comb begin
        addr_hit = 1'b1;
        rd_word  = '0;
        case (paddr)
            pmp_pkg::REG_CTRL: begin
                // Apply is never stored, so it reads back as zero
                rd_word[pmp_pkg::CTRL_ENABLE_BIT] = enable;
            end
            pmp_pkg::REG_PERIOD:   rd_word[COUNTER_WIDTH-1:0] = period;
            pmp_pkg::REG_PHASE:    rd_word[COUNTER_WIDTH-1:0] = phase;
            pmp_pkg::REG_DEADTIME: rd_word[COUNTER_WIDTH-1:0] = dead_time;
            pmp_pkg::REG_STATUS: begin
                rd_word[pmp_pkg::STATUS_CFG_ERR_BIT] = err_flag;
                rd_word[pmp_pkg::STATUS_LOADED_BIT]  = loaded_flag;
            end
            default: addr_hit = 1'b0;
        endcase
    end

    // Configuration registers, written on the edge closing the access phase
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            period    <= '0;
            phase     <= '0;
            dead_time <= '0;
            enable    <= 1'b0;
            apply     <= 1'b0;
        end else begin
            // The apply strobe lasts exactly one cycle
            apply <= wr_en && (paddr == pmp_pkg::REG_CTRL) && pwdata[pmp_pkg::CTRL_APPLY_BIT];
            if (wr_en) begin
                case (paddr)
                    pmp_pkg::REG_CTRL:     enable    <= pwdata[pmp_pkg::CTRL_ENABLE_BIT];
                    pmp_pkg::REG_PERIOD:   period    <= pwdata[COUNTER_WIDTH-1:0];
                    pmp_pkg::REG_PHASE:    phase     <= pwdata[COUNTER_WIDTH-1:0];
                    pmp_pkg::REG_DEADTIME: dead_time <= pwdata[COUNTER_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Status flags
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            err_flag    <= 1'b0;
            loaded_flag <= 1'b0;
        end else begin
            // Error sticks until a good result comes back from the calculator
            if (cfg_err) begin
                err_flag <= 1'b1;
            end else if (result_valid) begin
                err_flag <= 1'b0;
            end
            // A new load wins over a simultaneous status read
            if (loaded) begin
                loaded_flag <= 1'b1;
            end else if (status_rd) begin
                loaded_flag <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- modulation/pmp_mod_calc.sv
// Three-stage calculator that validates the settings and derives the leg thresholds
`timescale 1ns/1ps
`default_nettype none

module pmp_mod_calc #(
    parameter int COUNTER_WIDTH = 16
) (
    input  wire                      clock,
    input  wire                      arst_n,
    input  wire                      apply,
    input  wire  [COUNTER_WIDTH-1:0] period,
    input  wire  [COUNTER_WIDTH-1:0] phase,
    input  wire  [COUNTER_WIDTH-1:0] dead_time,
    output logic                     result_valid,
    output logic                     cfg_err,
    output logic [COUNTER_WIDTH-1:0] period_out,
    output logic [COUNTER_WIDTH-1:0] half_period,
    output logic [COUNTER_WIDTH-1:0] half_plus_dead,
    output logic [COUNTER_WIDTH-1:0] sec_offset
);

    // The phase reduction is split so that the upper half of the steps
    // runs in stage two and the lower half in stage three
    localparam int SPLIT = COUNTER_WIDTH / 2;
    // Shifted copies of the period need twice the counter width
    localparam int WIDE  = 2 * COUNTER_WIDTH;

    logic                     s1_valid;
    logic [COUNTER_WIDTH-1:0] s1_period;
    logic [COUNTER_WIDTH-1:0] s1_phase;
    logic [COUNTER_WIDTH-1:0] s1_dead;
    logic [COUNTER_WIDTH-1:0] s1_half;
    logic                     s2_valid;
    logic                     s2_ok;
    logic [COUNTER_WIDTH-1:0] s2_period;
    logic [COUNTER_WIDTH-1:0] s2_dead;
    logic [COUNTER_WIDTH-1:0] s2_half;
    logic [COUNTER_WIDTH-1:0] s2_rem;
    logic [WIDE-1:0]          rem_hi;
    logic [WIDE-1:0]          rem_lo;

    // Valid flags follow each request down the three stages
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
            cfg_err      <= 1'b0;
        end else begin
            s1_valid     <= apply;
            s2_valid     <= s1_valid;
            // Exactly one of the two answers per request
            result_valid <= s2_valid && s2_ok;
            cfg_err      <= s2_valid && !s2_ok;
        end
    end

    // Upper reduction steps subtract period << k whenever it still fits
    always_comb begin
        rem_hi = WIDE'(s1_phase);
        for (int k = COUNTER_WIDTH - 1; k >= SPLIT; k--) begin
            if (rem_hi >= (WIDE'(s1_period) << k)) begin
                rem_hi = rem_hi - (WIDE'(s1_period) << k);
            end
        end
    end

    // Lower reduction steps finish the modulo in stage three
    always_comb begin
        rem_lo = WIDE'(s2_rem);
        for (int k = SPLIT - 1; k >= 0; k--) begin
            if (rem_lo >= (WIDE'(s2_period) << k)) begin
                rem_lo = rem_lo - (WIDE'(s2_period) << k);
            end
        end
    end

    // Two requests can be in flight in the payload registers
    always_ff @(posedge clock) begin
        // Stage one captures the settings and halves the period
        if (apply) begin
            s1_period <= period;
            s1_phase  <= phase;
            s1_dead   <= dead_time;
            s1_half   <= period >> 1;
        end
        // Stage two checks the settings
        // The partial remainder never exceeds the phase, so its low bits hold it
        if (s1_valid) begin
            s2_period <= s1_period;
            s2_dead   <= s1_dead;
            s2_half   <= s1_half;
            s2_rem    <= rem_hi[COUNTER_WIDTH-1:0];
            s2_ok     <= (s1_period >= COUNTER_WIDTH'(4)) && (s1_dead < s1_half);
        end
        // Stage three only updates the outputs on a good result
        if (s2_valid && s2_ok) begin
            period_out     <= s2_period;
            half_period    <= s2_half;
            half_plus_dead <= s2_half + s2_dead;
            sec_offset     <= rem_lo[COUNTER_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

//--- pwm/pmp_pwm_gen.sv
// Period counter, shadow thresholds and two comparator legs driving the four gates
`timescale 1ns/1ps
`default_nettype none

module pmp_pwm_gen #(
    parameter int COUNTER_WIDTH = 16
) (
    input  wire                      clock,
    input  wire                      arst_n,
    input  wire                      enable,
    input  wire                      result_valid,
    input  wire  [COUNTER_WIDTH-1:0] period_out,
    input  wire  [COUNTER_WIDTH-1:0] half_period,
    input  wire  [COUNTER_WIDTH-1:0] half_plus_dead,
    input  wire  [COUNTER_WIDTH-1:0] sec_offset,
    input  wire  [COUNTER_WIDTH-1:0] dead_time,
    output logic                     loaded,
    output logic                     pwm_p_hi,
    output logic                     pwm_p_lo,
    output logic                     pwm_s_hi,
    output logic                     pwm_s_lo
);

    pmp_pkg::pmp_gen_state_e  state;
    logic [COUNTER_WIDTH-1:0] count;
    logic                     pending;
    logic                     sh_valid;
    logic                     wrap;
    logic                     load_now;
    logic [COUNTER_WIDTH-1:0] pos_p;
    logic [COUNTER_WIDTH-1:0] pos_s;
    // Shadow set used by the comparators
    logic [COUNTER_WIDTH-1:0] sh_period, sh_half, sh_hpd, sh_sec, sh_dead;
    // Staging set waiting for the next wrap
    logic [COUNTER_WIDTH-1:0] st_period, st_half, st_hpd, st_sec, st_dead;

    // Position of a leg within the period, offset taken modulo the period
    function automatic logic [COUNTER_WIDTH-1:0] local_pos(
        input logic [COUNTER_WIDTH-1:0] cnt,
        input logic [COUNTER_WIDTH-1:0] offset,
        input logic [COUNTER_WIDTH-1:0] per
    );
        // Both branches stay below the period, so the sum cannot overflow
        if (cnt >= offset) begin
            return cnt - offset;
        end
        return cnt + per - offset;
    endfunction

    assign wrap     = (state == pmp_pkg::GEN_RUN) && (count == sh_period - COUNTER_WIDTH'(1));
    // Idle loads at once, a running generator only at the end of a period
    assign load_now = (result_valid || pending) && ((state == pmp_pkg::GEN_IDLE) || wrap);
    assign pos_p    = local_pos(count, '0, sh_period);
    assign pos_s    = local_pos(count, sh_sec, sh_period);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state    <= pmp_pkg::GEN_IDLE;
            count    <= '0;
            pending  <= 1'b0;
            sh_valid <= 1'b0;
            loaded   <= 1'b0;
            pwm_p_hi <= 1'b0;
            pwm_p_lo <= 1'b0;
            pwm_s_hi <= 1'b0;
            pwm_s_lo <= 1'b0;
        end else begin
            loaded <= load_now;
            if (load_now) begin
                pending  <= 1'b0;
                sh_valid <= 1'b1;
            end else if (result_valid) begin
                pending <= 1'b1;
            end
            // The counter always restarts from zero on entry to GEN_RUN
            case (state)
                pmp_pkg::GEN_IDLE: begin
                    count <= '0;
                    if (enable && sh_valid) begin
                        state <= pmp_pkg::GEN_RUN;
                    end
                end
                default: begin
                    if (!enable) begin
                        state <= pmp_pkg::GEN_IDLE;
                        count <= '0;
                    end else begin
                        count <= wrap ? '0 : count + COUNTER_WIDTH'(1);
                    end
                end
            endcase
            // Registered gates, forced low whenever the leg is not running
            if ((state == pmp_pkg::GEN_RUN) && enable) begin
                pwm_p_hi <= (pos_p >= sh_dead) && (pos_p < sh_half);
                pwm_p_lo <= (pos_p >= sh_hpd) && (pos_p < sh_period);
                pwm_s_hi <= (pos_s >= sh_dead) && (pos_s < sh_half);
                pwm_s_lo <= (pos_s >= sh_hpd) && (pos_s < sh_period);
            end else begin
                pwm_p_hi <= 1'b0;
                pwm_p_lo <= 1'b0;
                pwm_s_hi <= 1'b0;
                pwm_s_lo <= 1'b0;
            end
        end
    end

    // Threshold payload, a fresh result bypasses the staging set
    always_ff @(posedge clock) begin
        if (result_valid && !load_now) begin
            st_period <= period_out;
            st_half   <= half_period;
            st_hpd    <= half_plus_dead;
            st_sec    <= sec_offset;
            st_dead   <= dead_time;
        end
        if (load_now) begin
            sh_period <= result_valid ? period_out     : st_period;
            sh_half   <= result_valid ? half_period    : st_half;
            sh_hpd    <= result_valid ? half_plus_dead : st_hpd;
            sh_sec    <= result_valid ? sec_offset     : st_sec;
            sh_dead   <= result_valid ? dead_time      : st_dead;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pmp_top.sv
// Top level joining the APB registers, the modulation calculator and the gate generator
`timescale 1ns/1ps
`default_nettype none

module pmp_top #(
    parameter int COUNTER_WIDTH = 16
) (
    input  wire                                  clock,
    input  wire                                  arst_n,
    input  wire  [pmp_pkg::APB_ADDR_WIDTH-1:0]   paddr,
    input  wire                                  psel,
    input  wire                                  penable,
    input  wire                                  pwrite,
    input  wire  [pmp_pkg::APB_DATA_WIDTH-1:0]   pwdata,
    output logic [pmp_pkg::APB_DATA_WIDTH-1:0]   prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic                                 pwm_p_hi,
    output logic                                 pwm_p_lo,
    output logic                                 pwm_s_hi,
    output logic                                 pwm_s_lo
);

    // Raw settings and strobes from the register block
    wire [COUNTER_WIDTH-1:0] period, phase, dead_time;
    wire                     apply, enable;
    // Calculator answers
    wire                     result_valid, cfg_err;
    wire [COUNTER_WIDTH-1:0] period_out, half_period, half_plus_dead, sec_offset;
    // Load acknowledge from the generator back to the status word
    wire                     loaded;

    pmp_apb_regs #(.COUNTER_WIDTH(COUNTER_WIDTH)) u_regs (
        .clock(clock), .arst_n(arst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cfg_err(cfg_err), .result_valid(result_valid), .loaded(loaded),
        .period(period), .phase(phase), .dead_time(dead_time),
        .apply(apply), .enable(enable)
    );

    pmp_mod_calc #(.COUNTER_WIDTH(COUNTER_WIDTH)) u_calc (
        .clock(clock), .arst_n(arst_n), .apply(apply),
        .period(period), .phase(phase), .dead_time(dead_time),
        .result_valid(result_valid), .cfg_err(cfg_err),
        .period_out(period_out), .half_period(half_period),
        .half_plus_dead(half_plus_dead), .sec_offset(sec_offset)
    );

    // Dead time comes straight from the register block and is latched with each result
    pmp_pwm_gen #(.COUNTER_WIDTH(COUNTER_WIDTH)) u_gen (
        .clock(clock), .arst_n(arst_n), .enable(enable), .result_valid(result_valid),
        .period_out(period_out), .half_period(half_period),
        .half_plus_dead(half_plus_dead), .sec_offset(sec_offset), .dead_time(dead_time),
        .loaded(loaded),
        .pwm_p_hi(pwm_p_hi), .pwm_p_lo(pwm_p_lo), .pwm_s_hi(pwm_s_hi), .pwm_s_lo(pwm_s_lo)
    );

endmodule

`default_nettype wire

//--- bench/pmp_assertions.sv
// Concurrent protocol and gate safety assertions bound to the top level
`timescale 1ns/1ps
`default_nettype none

module pmp_assertions (
    input wire                          clock,
    input wire                          arst_n,
    input wire                          psel,
    input wire                          penable,
    input wire                          pready,
    input wire                          pwm_p_hi,
    input wire                          pwm_p_lo,
    input wire                          pwm_s_hi,
    input wire                          pwm_s_lo,
    input wire                          result_valid,
    input wire                          cfg_err,
    input wire pmp_pkg::pmp_gen_state_e gen_state
);

    // Number of failed assertions, read by the testbench for its verdict
    int fail_count = 0;

    // A shoot-through on either leg would short the bridge supply
    assert property (@(posedge clock) disable iff (!arst_n) !(pwm_p_hi && pwm_p_lo))
        else begin
            fail_count++;
            $error("Primary leg high and low gates are on together");
        end

    assert property (@(posedge clock) disable iff (!arst_n) !(pwm_s_hi && pwm_s_lo))
        else begin
            fail_count++;
            $error("Secondary leg high and low gates are on together");
        end

    // The slave has no wait states
    assert property (@(posedge clock) disable iff (!arst_n) (psel && penable) |-> pready)
        else begin
            fail_count++;
            $error("pready is low in an APB access phase");
        end

    // An idle generator keeps every gate off
    assert property (@(posedge clock) disable iff (!arst_n)
        (gen_state == pmp_pkg::GEN_IDLE) |-> !(pwm_p_hi || pwm_p_lo || pwm_s_hi || pwm_s_lo))
        else begin
            fail_count++;
            $error("A gate is on while the generator is idle");
        end

    // Each calculation gives either a result or an error, never both
    assert property (@(posedge clock) disable iff (!arst_n) !(result_valid && cfg_err))
        else begin
            fail_count++;
            $error("result_valid and cfg_err are high in the same cycle");
        end

endmodule

// Attach the checker to every instance of the top level
bind pmp_top pmp_assertions u_assert (
    .clock(clock), .arst_n(arst_n),
    .psel(psel), .penable(penable), .pready(pready),
    .pwm_p_hi(pwm_p_hi), .pwm_p_lo(pwm_p_lo), .pwm_s_hi(pwm_s_hi), .pwm_s_lo(pwm_s_lo),
    .result_valid(result_valid), .cfg_err(cfg_err), .gen_state(u_gen.state)
);

`default_nettype wire

//--- bench/pmp_tb.sv
// Testbench with clock, reset, APB tasks, waveform measurement, watchdog and verdict
`timescale 1ns/1ps
`default_nettype none

module pmp_tb;

    localparam int     NUM_RANDOM    = 6;
    localparam int     CLK_HALF      = 10;
    localparam longint APB_MARGIN_NS = 40000;
    localparam logic [31:0] CTRL_RUN_APPLY =
        (32'd1 << pmp_pkg::CTRL_ENABLE_BIT) | (32'd1 << pmp_pkg::CTRL_APPLY_BIT);

    logic        clock;
    logic        arst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready, pslverr;
    wire         pwm_p_hi, pwm_p_lo, pwm_s_hi, pwm_s_lo;

    integer seed;
    int     check_errors;
    longint limit_ns;
    int     rnd_per[NUM_RANDOM];
    int     rnd_ph[NUM_RANDOM];
    int     rnd_dead[NUM_RANDOM];

    pmp_top #(.COUNTER_WIDTH(16)) DUT (
        .clock(clock), .arst_n(arst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .pwm_p_hi(pwm_p_hi), .pwm_p_lo(pwm_p_lo), .pwm_s_hi(pwm_s_hi), .pwm_s_lo(pwm_s_lo)
    );

    always #(CLK_HALF) clock = ~clock;

    task automatic check_value(input string name, input logic signed [63:0] expected,
                               input logic signed [63:0] actual);
        if (expected !== actual) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, expected,
                     actual);
        end
    endtask

    task automatic report_failure(input string msg);
        check_errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // One zero-wait APB transfer with inputs changing on the falling edge only
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge clock);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clock);
        penable = 1'b1;
        // Read data and pslverr are combinational and settled mid access phase
        #(CLK_HALF / 2);
        rdata = prdata;
        err   = pslverr;
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        apb_access(1'b1, addr, data, rd, err);
        if (err) report_failure($sformatf("APB write to 0x%h was rejected", addr));
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        logic err;
        apb_access(1'b0, addr, '0, data, err);
        if (err) report_failure($sformatf("APB read from 0x%h was rejected", addr));
    endtask

    // Program a setting and start a calculation with the generator enabled
    task automatic configure(input int per, input int ph, input int dead);
        apb_write(pmp_pkg::REG_PERIOD, per);
        apb_write(pmp_pkg::REG_PHASE, ph);
        apb_write(pmp_pkg::REG_DEADTIME, dead);
        apb_write(pmp_pkg::REG_CTRL, CTRL_RUN_APPLY);
    endtask

    // Poll the status word until the loaded bit shows up
    // last_zero is the start of the last read that still saw it clear
    task automatic wait_loaded(output logic [31:0] status, output time last_zero);
        time start;
        last_zero = 0;
        do begin
            start = $time;
            apb_read(pmp_pkg::REG_STATUS, status);
            if (!status[pmp_pkg::STATUS_LOADED_BIT]) last_zero = start;
        end while (!status[pmp_pkg::STATUS_LOADED_BIT]);
    endtask

    function automatic logic gate_level(input int idx);
        case (idx)
            0:       return pwm_p_hi;
            1:       return pwm_p_lo;
            2:       return pwm_s_hi;
            default: return pwm_s_lo;
        endcase
    endfunction

    function automatic string gate_name(input int idx);
        case (idx)
            0:       return "pwm_p_hi";
            1:       return "pwm_p_lo";
            2:       return "pwm_s_hi";
            default: return "pwm_s_lo";
        endcase
    endfunction

    // Widths in cycles of one full on pulse and the off time that follows it
    task automatic measure_pulse(input int idx, output int hi_w, output int lo_w);
        @(negedge clock);
        while (gate_level(idx)) @(negedge clock);
        while (!gate_level(idx)) @(negedge clock);
        hi_w = 0;
        while (gate_level(idx)) begin
            hi_w++;
            @(negedge clock);
        end
        lo_w = 0;
        while (!gate_level(idx)) begin
            lo_w++;
            @(negedge clock);
        end
    endtask

    // Cycles from a pwm_p_hi rising edge to the next pwm_s_hi rising edge
    task automatic measure_lag(output int lag);
        logic prev_p;
        logic prev_s;
        prev_p = 1'b1;
        prev_s = 1'b1;
        @(negedge clock);
        while (!(!prev_p && pwm_p_hi)) begin
            prev_p = pwm_p_hi;
            prev_s = pwm_s_hi;
            @(negedge clock);
        end
        lag = 0;
        while (!(!prev_s && pwm_s_hi)) begin
            prev_s = pwm_s_hi;
            lag++;
            @(negedge clock);
        end
    endtask

    // Expected widths follow the window rules
    // The expected lag is the phase modulo the period
    task automatic check_waveform(input int per, input int ph, input int dead);
        int half;
        int on_w;
        int lag;
        int hi_w[4];
        int lo_w[4];
        half = per >> 1;
        fork
            measure_pulse(0, hi_w[0], lo_w[0]);
            measure_pulse(1, hi_w[1], lo_w[1]);
            measure_pulse(2, hi_w[2], lo_w[2]);
            measure_pulse(3, hi_w[3], lo_w[3]);
            measure_lag(lag);
        join
        for (int i = 0; i < 4; i++) begin
            on_w = (i % 2 == 0) ? half - dead : per - half - dead;
            check_value({gate_name(i), " on width"}, on_w, hi_w[i]);
            check_value({gate_name(i), " off width"}, per - on_w, lo_w[i]);
        end
        check_value("pwm_s_hi rise delay", ph % per, lag);
    endtask

    // The watchdog waits until the run length is known
    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] status;
        logic        err;
        time         last_zero;
        time         t_rise;
        int          width;
        int          pulses;
        bit          found;
        int          cur_per;
        int          cur_ph;
        int          cur_dead;
        longint      period_sum;

        clock        = 1'b0;
        arst_n       = 1'b0;
        paddr        = '0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        pwdata       = '0;
        check_errors = 0;
        seed         = 32'h14362877;

        // Settings are drawn up front so that the watchdog knows the run length
        // Entry 3 gets a dead time of at least half the period and must be rejected
        period_sum = 40 + 40 + 40 + 3;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd_per[i] = 8 + $unsigned($random(seed)) % 56;
            rnd_ph[i]  = $unsigned($random(seed)) % (2 * rnd_per[i]);
            if (i == 3) begin
                rnd_dead[i] = (rnd_per[i] >> 1) + $unsigned($random(seed)) % 4;
            end else begin
                rnd_dead[i] = $unsigned($random(seed)) % (rnd_per[i] >> 1);
            end
            period_sum += rnd_per[i];
        end
        limit_ns = period_sum * 20 * 6 + APB_MARGIN_NS;

        repeat (16) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        // The assertions watch the gates while enable stays low
        repeat (20) @(negedge clock);
        // A nonzero period shows up if an unmapped offset aliases onto it
        apb_write(pmp_pkg::REG_PERIOD, 40);
        apb_access(1'b0, 8'h14, '0, rd, err);
        check_value("pslverr on unmapped read", 1, err);
        check_value("prdata on unmapped read", 0, rd);
        apb_access(1'b1, 8'h24, 32'h0000_1234, rd, err);
        check_value("pslverr on unmapped write", 1, err);
        apb_read(pmp_pkg::REG_PERIOD, rd);
        check_value("period after unmapped write", 40, rd);

        // The first phase lies above the period and has to wrap
        configure(40, 50, 4);
        apb_read(pmp_pkg::REG_PERIOD, rd);
        check_value("period readback", 40, rd);
        apb_read(pmp_pkg::REG_PHASE, rd);
        check_value("phase readback", 50, rd);
        apb_read(pmp_pkg::REG_DEADTIME, rd);
        check_value("dead_time readback", 4, rd);
        apb_read(pmp_pkg::REG_CTRL, rd);
        check_value("ctrl readback", 32'd1 << pmp_pkg::CTRL_ENABLE_BIT, rd);
        wait_loaded(status, last_zero);
        check_value("status error bit", 0, status[pmp_pkg::STATUS_CFG_ERR_BIT]);
        check_waveform(40, 50, 4);

        // Each invalid set gets its answer after the fixed calculator latency
        apb_write(pmp_pkg::REG_DEADTIME, 25);
        apb_write(pmp_pkg::REG_CTRL, CTRL_RUN_APPLY);
        repeat (5) @(negedge clock);
        apb_read(pmp_pkg::REG_STATUS, status);
        check_value("status error bit", 1, status[pmp_pkg::STATUS_CFG_ERR_BIT]);
        check_waveform(40, 50, 4);
        // A valid apply in between clears the sticky error bit
        apb_write(pmp_pkg::REG_DEADTIME, 4);
        apb_write(pmp_pkg::REG_CTRL, CTRL_RUN_APPLY);
        wait_loaded(status, last_zero);
        check_value("status error bit", 0, status[pmp_pkg::STATUS_CFG_ERR_BIT]);
        apb_write(pmp_pkg::REG_PERIOD, 3);
        apb_write(pmp_pkg::REG_DEADTIME, 0);
        apb_write(pmp_pkg::REG_CTRL, CTRL_RUN_APPLY);
        repeat (5) @(negedge clock);
        apb_read(pmp_pkg::REG_STATUS, status);
        check_value("status error bit", 1, status[pmp_pkg::STATUS_CFG_ERR_BIT]);
        check_waveform(40, 50, 4);

        // Every pulse during a live update must have either the old or the new width
        apb_write(pmp_pkg::REG_PERIOD, 40);
        apb_write(pmp_pkg::REG_DEADTIME, 10);
        found  = 1'b0;
        pulses = 0;
        t_rise = 0;
        fork
            begin
                apb_write(pmp_pkg::REG_CTRL, CTRL_RUN_APPLY);
                wait_loaded(status, last_zero);
            end
            begin
                @(negedge clock);
                while (pwm_p_hi) @(negedge clock);
                while (!found && pulses < 8) begin
                    while (!pwm_p_hi) @(negedge clock);
                    t_rise = $time;
                    width  = 0;
                    while (pwm_p_hi) begin
                        width++;
                        @(negedge clock);
                    end
                    pulses++;
                    if (width == 10) found = 1'b1;
                    else check_value("pwm_p_hi width across update", 16, width);
                end
            end
        join
        if (!found) begin
            report_failure("the new pwm_p_hi width never appeared after the update");
        end else if (t_rise < last_zero) begin
            report_failure("a new-width pulse started before the loaded bit was set");
        end
        check_value("status error bit", 0, status[pmp_pkg::STATUS_CFG_ERR_BIT]);
        check_waveform(40, 50, 10);
        cur_per  = 40;
        cur_ph   = 50;
        cur_dead = 10;

        // Random settings are applied while the generator runs
        for (int i = 0; i < NUM_RANDOM; i++) begin
            configure(rnd_per[i], rnd_ph[i], rnd_dead[i]);
            if (i == 3) begin
                repeat (5) @(negedge clock);
                apb_read(pmp_pkg::REG_STATUS, status);
                check_value("status error bit", 1, status[pmp_pkg::STATUS_CFG_ERR_BIT]);
            end else begin
                wait_loaded(status, last_zero);
                check_value("status error bit", 0, status[pmp_pkg::STATUS_CFG_ERR_BIT]);
                cur_per  = rnd_per[i];
                cur_ph   = rnd_ph[i];
                cur_dead = rnd_dead[i];
            end
            check_waveform(cur_per, cur_ph, cur_dead);
        end

        // Clearing enable stops the gates within one cycle
        apb_write(pmp_pkg::REG_CTRL, '0);
        @(negedge clock);
        check_value("gates after disable", 0, {pwm_p_hi, pwm_p_lo, pwm_s_hi, pwm_s_lo});
        repeat (10) @(negedge clock);

        $display("Check errors: %0d, assertion failures: %0d", check_errors,
                 DUT.u_assert.fail_count);
        if (check_errors == 0 && DUT.u_assert.fail_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pmp.f
common/pmp_pkg.sv
verilog/pmp_apb_regs.sv
modulation/pmp_mod_calc.sv
pwm/pmp_pwm_gen.sv
verilog/pmp_top.sv
bench/pmp_assertions.sv
bench/pmp_tb.sv
